//--- wisc16_pipe.f
+incdir+include
design/wisc16_pkg.sv
design/decode_ctrl.sv
design/reg_file.sv
design/decode_stage.sv
design/exec_stage.sv
design/wisc16_pipe.sv
verification/tb_clock_gen.sv
verification/wisc16_pipe_tb.sv

//--- Bender.yml
package:
  name: wisc16_pipe

export_include_dirs:
  - include

sources:
  - files:
      - design/wisc16_pkg.sv
      - design/decode_ctrl.sv
      - design/reg_file.sv
      - design/decode_stage.sv
      - design/exec_stage.sv
      - design/wisc16_pipe.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/wisc16_pipe_tb.sv

//--- verification/wisc16_pipe_tb.sv
// testbench for the wisc16 pipeline
// a register model applied in program order predicts every result strobe
// stimulus comes from a fixed-seed LCG, results are due two cycles after issue
// outputs are sampled on the falling edge, inputs change 1 ns after the rising edge
`timescale 1ns/1ps
`include "wisc16_consts.svh"

module wisc16_pipe_tb;
   import wisc16_pkg::*;

   localparam int RESET_CYCLES = 3;
   localparam int N_RAND_ALU   = 40;
   localparam int N_RAND_IMM   = 40;
   localparam int N_CHAIN      = 24;
   localparam int N_ILLEGAL    = 4;
   localparam int N_AFTER_HALT = 6;
   localparam int TOTAL_INSTS  = 8 + 8 + N_RAND_ALU + 4 + N_RAND_IMM + 1 + N_CHAIN
                                 + 4 * N_ILLEGAL + 1 + 1 + N_AFTER_HALT;
   localparam int MAX_CYCLES   = 20 * TOTAL_INSTS + RESET_CYCLES;

   // one predicted result strobe
   typedef struct packed {
      logic     halt;
      logic     err;
      logic     wr;
      reg_sel_t sel;
      word_t    data;
   } exp_t;

   logic     clk, arst_n, inst_valid;
   inst_t    inst;
   logic     result_valid, result_wr, result_err, halted;
   reg_sel_t result_reg;
   word_t    result_data;

   word_t       model_regs [8];
   logic        model_halted, halt_seen, issue_expect;
   logic  [1:0] pend;
   exp_t        exp_q [$];
   exp_t        head;
   int unsigned lcg_state;
   int          error_count, check_count, test_errors, k;
   int          cycle_count = 0;
   logic [15:0] r;
   reg_sel_t    prev, dst;
   logic  [4:0] op;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   wisc16_pipe wisc16_pipe_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .inst_valid   (inst_valid),
      .inst         (inst),
      .result_valid (result_valid),
      .result_reg   (result_reg),
      .result_data  (result_data),
      .result_wr    (result_wr),
      .result_err   (result_err),
      .halted       (halted)
   );

   function logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   function logic is_legal_op(input logic [4:0] opc);
      return opc == `WISC_OPC_HALT || opc == `WISC_OPC_NOP || opc == `WISC_OPC_RTYPE
          || opc == `WISC_OPC_ADDI || opc == `WISC_OPC_ANDNI || opc == `WISC_OPC_LBI
          || opc == `WISC_OPC_SLBI;
   endfunction

   // any instruction that writes a register, fields left random
   function inst_t rand_writer();
      logic [15:0] bits;
      bits = lcg_next();
      case (lcg_next() % 5)
         0:       return {`WISC_OPC_RTYPE, bits[10:0]};
         1:       return {`WISC_OPC_ADDI, bits[10:0]};
         2:       return {`WISC_OPC_ANDNI, bits[10:0]};
         3:       return {`WISC_OPC_LBI, bits[10:0]};
         default: return {`WISC_OPC_SLBI, bits[10:0]};
      endcase
   endfunction

   task mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task failure(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   // reference model, nothing is accepted once a HALT has been issued
   task model_issue(input inst_t w);
      word_t a, b;
      exp_t  e;
      a = model_regs[w[10:8]];
      b = model_regs[w[7:5]];
      e = '0;
      case (w[15:11])
         `WISC_OPC_HALT: e.halt = 1'b1;
         `WISC_OPC_NOP: ;
         `WISC_OPC_RTYPE: begin
            e.wr  = 1'b1;
            e.sel = w[4:2];
            case (w[1:0])
               `WISC_FN_ADD: e.data = a + b;
               `WISC_FN_SUB: e.data = a - b;
               `WISC_FN_XOR: e.data = a ^ b;
               default:      e.data = a & b;
            endcase
         end
         `WISC_OPC_ADDI: begin
            e.wr   = 1'b1;
            e.sel  = w[7:5];
            e.data = a + {{11{w[4]}}, w[4:0]};
         end
         `WISC_OPC_ANDNI: begin
            e.wr   = 1'b1;
            e.sel  = w[7:5];
            e.data = a & ~{11'b0, w[4:0]};
         end
         `WISC_OPC_LBI: begin
            e.wr   = 1'b1;
            e.sel  = w[10:8];
            e.data = {{8{w[7]}}, w[7:0]};
         end
         `WISC_OPC_SLBI: begin
            e.wr   = 1'b1;
            e.sel  = w[10:8];
            e.data = {a[7:0], w[7:0]};
         end
         default: e.err = 1'b1;
      endcase
      issue_expect = !model_halted;
      if (!model_halted) begin
         if (e.wr) begin
            model_regs[e.sel] = e.data;
         end
         exp_q.push_back(e);
         model_halted = e.halt;
      end
   endtask

   task issue(input inst_t w);
      @(posedge clk);
      #1;
      inst_valid = 1'b1;
      inst       = w;
      model_issue(w);
   endtask

   // ADDI with a zero immediate copies a register onto itself
   task read_back(input reg_sel_t sel);
      issue({`WISC_OPC_ADDI, sel, sel, 5'd0});
   endtask

   task drain();
      @(posedge clk);
      #1;
      inst_valid   = 1'b0;
      issue_expect = 1'b0;
      while (exp_q.size() != 0 || pend != 2'b00) begin
         @(posedge clk);
      end
   endtask

   task end_test(input string name);
      string verdict;
      verdict = (error_count == test_errors) ? "passed" : "FAILED";
      $display("test %s: %s, %0d errors", name, verdict, error_count - test_errors);
      test_errors = error_count;
   endtask

   // a strobe is due on the third falling edge after the issue
   always @(negedge clk) begin
      if (arst_n) begin
         check_count++;
         assert (result_valid == pend[1])
            else mismatch($sformatf("result_valid %0b, expected %0b", result_valid, pend[1]));
         if (result_valid && exp_q.size() > 0) begin
            check_count++;
            head = exp_q.pop_front();
            if (head.halt) begin
               halt_seen = 1'b1;
            end
            assert (result_wr == head.wr)
               else mismatch($sformatf("result_wr %0b, expected %0b", result_wr, head.wr));
            assert (result_err == head.err)
               else mismatch($sformatf("result_err %0b, expected %0b", result_err, head.err));
            if (head.wr) begin
               assert (result_reg == head.sel)
                  else mismatch($sformatf("result_reg %0d, expected %0d", result_reg, head.sel));
               assert (result_data == head.data)
                  else mismatch($sformatf("result_data %h, expected %h", result_data, head.data));
            end
         end else if (result_valid) begin
            failure("result strobe arrived with no instruction outstanding");
         end
         assert (result_valid || !result_err)
            else mismatch("result_err high without a result strobe");
         assert (halted == halt_seen)
            else mismatch($sformatf("halted %0b, expected %0b", halted, halt_seen));
         pend = {pend[0], issue_expect};
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      inst_valid   = 1'b0;
      inst         = '0;
      issue_expect = 1'b0;
      pend         = '0;
      halt_seen    = 1'b0;
      model_halted = 1'b0;
      lcg_state    = 32'd75410;
      error_count  = 0;
      check_count  = 0;
      test_errors  = 0;
      for (k = 0; k < 8; k++) begin
         model_regs[k] = '0;
      end
      @(posedge arst_n);

      // quiet after reset, then untouched registers must read zero
      repeat (4) @(negedge clk);
      assert (!result_valid && !result_err && !halted)
         else mismatch("outputs active after reset with no instruction issued");
      for (k = 0; k < 8; k++) begin
         issue({`WISC_OPC_RTYPE, k[2:0], k[2:0] + 3'd1, k[2:0], `WISC_FN_ADD});
      end
      drain();
      end_test("reset");

      for (k = 0; k < 8; k++) begin
         r = lcg_next();
         issue({`WISC_OPC_LBI, k[2:0], r[7:0]});
      end
      for (k = 0; k < N_RAND_ALU; k++) begin
         r = lcg_next();
         issue({`WISC_OPC_RTYPE, r[10:0]});
      end
      drain();
      end_test("rtype");

      // immediates with the top bit set first
      issue({`WISC_OPC_ADDI, 3'd2, 3'd1, 5'h10});
      issue({`WISC_OPC_ANDNI, 3'd3, 3'd4, 5'h13});
      issue({`WISC_OPC_LBI, 3'd5, 8'h80});
      issue({`WISC_OPC_SLBI, 3'd5, 8'hf0});
      for (k = 0; k < N_RAND_IMM; k++) begin
         r = lcg_next();
         case (r[12:11])
            2'd0:    op = `WISC_OPC_ADDI;
            2'd1:    op = `WISC_OPC_ANDNI;
            2'd2:    op = `WISC_OPC_LBI;
            default: op = `WISC_OPC_SLBI;
         endcase
         issue({op, r[10:0]});
      end
      drain();
      end_test("immediate");

      // each instruction reads the register written by the one before it
      r = lcg_next();
      prev = r[10:8];
      issue({`WISC_OPC_LBI, prev, r[7:0]});
      for (k = 0; k < N_CHAIN; k++) begin
         r = lcg_next();
         case (r[12:11])
            2'd0: begin
               dst = r[4:2];
               issue({`WISC_OPC_RTYPE, prev, (k[0] ? prev : r[7:5]), dst, r[1:0]});
            end
            2'd1: begin
               dst = r[7:5];
               issue({`WISC_OPC_ADDI, prev, dst, r[4:0]});
            end
            2'd2: begin
               dst = r[7:5];
               issue({`WISC_OPC_ANDNI, prev, dst, r[4:0]});
            end
            default: begin
               dst = prev;
               issue({`WISC_OPC_SLBI, prev, r[7:0]});
            end
         endcase
         prev = dst;
      end
      drain();
      end_test("forwarding");

      // every field an illegal word could name must keep its value
      for (k = 0; k < N_ILLEGAL; k++) begin
         r = lcg_next();
         while (is_legal_op(r[15:11])) begin
            r = lcg_next();
         end
         issue(r);
         read_back(r[10:8]);
         read_back(r[7:5]);
         read_back(r[4:2]);
      end
      // a NOP gives a strobe with neither write nor error
      r = lcg_next();
      issue({`WISC_OPC_NOP, r[10:0]});
      drain();
      end_test("illegal");

      // first batch lands behind the HALT in ID/EX, second after halted rises
      r = lcg_next();
      issue({`WISC_OPC_HALT, r[10:0]});
      for (k = 0; k < N_AFTER_HALT / 2; k++) begin
         issue(rand_writer());
      end
      drain();
      for (k = 0; k < N_AFTER_HALT - N_AFTER_HALT / 2; k++) begin
         issue(rand_writer());
      end
      drain();
      repeat (4) @(negedge clk);
      assert (halted)
         else mismatch("halted dropped after the HALT result");
      end_test("halt");

      repeat (2) @(posedge clk);
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- verification/tb_clock_gen.sv
// clock and reset source for the testbench
// reset is released 1 ns after the last rising edge of the reset window
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

//--- design/wisc16_pipe.sv
// two-edge integer pipeline: decode then execute with writeback
// one instruction per cycle, no back-pressure, result two cycles after issue
// inst_valid is ignored once a HALT has been accepted
`timescale 1ns/1ps

module wisc16_pipe (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 inst_valid,
   input  wisc16_pkg::inst_t    inst,
   output logic                 result_valid,
   output wisc16_pkg::reg_sel_t result_reg,
   output wisc16_pkg::word_t    result_data,
   output logic                 result_wr,
   output logic                 result_err,
   output logic                 halted
);
   import wisc16_pkg::*;

   logic     ex_valid, ex_reg_write, ex_halt, ex_illegal;
   alu_op_t  ex_alu_op;
   word_t    ex_opnd_a, ex_opnd_b;
   reg_sel_t ex_dst;

   // writeback and forwarding path
   logic     wb_en;
   reg_sel_t wb_sel;
   word_t    wb_data;

   decode_stage u_decode (
      .clk          (clk),
      .arst_n       (arst_n),
      .inst_valid   (inst_valid),
      .inst         (inst),
      .halted       (halted),
      .wb_en        (wb_en),
      .wb_sel       (wb_sel),
      .wb_data      (wb_data),
      .ex_valid     (ex_valid),
      .ex_alu_op    (ex_alu_op),
      .ex_opnd_a    (ex_opnd_a),
      .ex_opnd_b    (ex_opnd_b),
      .ex_dst       (ex_dst),
      .ex_reg_write (ex_reg_write),
      .ex_halt      (ex_halt),
      .ex_illegal   (ex_illegal)
   );

   exec_stage u_exec (
      .clk          (clk),
      .arst_n       (arst_n),
      .ex_valid     (ex_valid),
      .ex_alu_op    (ex_alu_op),
      .ex_opnd_a    (ex_opnd_a),
      .ex_opnd_b    (ex_opnd_b),
      .ex_dst       (ex_dst),
      .ex_reg_write (ex_reg_write),
      .ex_halt      (ex_halt),
      .ex_illegal   (ex_illegal),
      .wb_en        (wb_en),
      .wb_sel       (wb_sel),
      .wb_data      (wb_data),
      .result_valid (result_valid),
      .result_reg   (result_reg),
      .result_data  (result_data),
      .result_wr    (result_wr),
      .result_err   (result_err),
      .halted       (halted)
   );

endmodule

//--- design/exec_stage.sv
// execute stage: ALU, writeback drive and result register
// writeback is combinational from ID/EX and lands in the register file at the edge
// halted is sticky until reset
`timescale 1ns/1ps
`include "wisc16_consts.svh"

module exec_stage (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 ex_valid,
   input  wisc16_pkg::alu_op_t  ex_alu_op,
   input  wisc16_pkg::word_t    ex_opnd_a,
   input  wisc16_pkg::word_t    ex_opnd_b,
   input  wisc16_pkg::reg_sel_t ex_dst,
   input  logic                 ex_reg_write,
   input  logic                 ex_halt,
   input  logic                 ex_illegal,
   output logic                 wb_en,
   output wisc16_pkg::reg_sel_t wb_sel,
   output wisc16_pkg::word_t    wb_data,
   output logic                 result_valid,
   output wisc16_pkg::reg_sel_t result_reg,
   output wisc16_pkg::word_t    result_data,
   output logic                 result_wr,
   output logic                 result_err,
   output logic                 halted
);
   import wisc16_pkg::*;

   word_t alu_res;

   always_comb begin
      case (ex_alu_op)
         `WISC_ALU_ADD:   alu_res = ex_opnd_a + ex_opnd_b;
         `WISC_ALU_SUB:   alu_res = ex_opnd_a - ex_opnd_b;
         `WISC_ALU_AND:   alu_res = ex_opnd_a & ex_opnd_b;
         `WISC_ALU_XOR:   alu_res = ex_opnd_a ^ ex_opnd_b;
         `WISC_ALU_ANDN:  alu_res = ex_opnd_a & ~ex_opnd_b;
         `WISC_ALU_PASSB: alu_res = ex_opnd_b;
         `WISC_ALU_SLBI:  alu_res = (ex_opnd_a << 8) | ex_opnd_b;
         default:         alu_res = '0;
      endcase
   end

   assign wb_en   = ex_valid & ex_reg_write;
   assign wb_sel  = ex_dst;
   assign wb_data = alu_res;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
         result_wr    <= 1'b0;
         result_err   <= 1'b0;
         halted       <= 1'b0;
      end else begin
         result_valid <= ex_valid;
         result_wr    <= wb_en;
         result_err   <= ex_valid & ex_illegal;
         // rises together with the HALT result strobe
         if (ex_valid && ex_halt) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         result_reg  <= ex_dst;
         result_data <= alu_res;
      end
   end

endmodule

//--- design/decode_stage.sv
// decode stage with the ID/EX pipeline register
// operands are forwarded from the writeback path of the instruction in execute
// strobes are dropped once a HALT sits in ID/EX or the core has halted
// no stalls: every accepted instruction enters ID/EX on the next edge
`timescale 1ns/1ps
`include "wisc16_consts.svh"

module decode_stage (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 inst_valid,
   input  wisc16_pkg::inst_t    inst,
   input  logic                 halted,
   input  logic                 wb_en,
   input  wisc16_pkg::reg_sel_t wb_sel,
   input  wisc16_pkg::word_t    wb_data,
   output logic                 ex_valid,
   output wisc16_pkg::alu_op_t  ex_alu_op,
   output wisc16_pkg::word_t    ex_opnd_a,
   output wisc16_pkg::word_t    ex_opnd_b,
   output wisc16_pkg::reg_sel_t ex_dst,
   output logic                 ex_reg_write,
   output logic                 ex_halt,
   output logic                 ex_illegal
);
   import wisc16_pkg::*;

   reg_sel_t rs_sel, rt_sel, dst;
   alu_op_t  alu_op;
   dst_sel_t dst_sel;
   logic     use_imm, imm_long, imm_signed, reg_write, halt, illegal;
   word_t    rf_a, rf_b, opnd_a, rt_val, imm_ext;
   logic     accept;

   assign rs_sel = inst[10:8];
   assign rt_sel = inst[7:5];

   decode_ctrl u_ctrl (
      .opcode     (inst[15:11]),
      .funct      (inst[1:0]),
      .alu_op     (alu_op),
      .dst_sel    (dst_sel),
      .use_imm    (use_imm),
      .imm_long   (imm_long),
      .imm_signed (imm_signed),
      .reg_write  (reg_write),
      .halt       (halt),
      .illegal    (illegal)
   );

   // written by execute on the same edge that loads ID/EX
   reg_file u_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_sel_a  (rs_sel),
      .rd_sel_b  (rt_sel),
      .wr_sel    (wb_sel),
      .wr_en     (wb_en),
      .wr_data   (wb_data),
      .rd_data_a (rf_a),
      .rd_data_b (rf_b)
   );

   // forward the value being written this cycle
   assign opnd_a = (wb_en && wb_sel == rs_sel) ? wb_data : rf_a;
   assign rt_val = (wb_en && wb_sel == rt_sel) ? wb_data : rf_b;

   always_comb begin
      if (imm_long) begin
         imm_ext = imm_signed ? {{(`WISC_DATA_W-8){inst[7]}}, inst[7:0]} : word_t'(inst[7:0]);
      end else begin
         imm_ext = imm_signed ? {{(`WISC_DATA_W-5){inst[4]}}, inst[4:0]} : word_t'(inst[4:0]);
      end
   end

   always_comb begin
      case (dst_sel)
         `WISC_DST_RT: dst = inst[7:5];
         `WISC_DST_RS: dst = inst[10:8];
         default:      dst = inst[4:2];
      endcase
   end

   // nothing new enters behind a HALT
   assign accept = inst_valid && !halted && !(ex_valid && ex_halt);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_valid     <= 1'b0;
         ex_reg_write <= 1'b0;
         ex_halt      <= 1'b0;
         ex_illegal   <= 1'b0;
      end else begin
         ex_valid     <= accept;
         ex_reg_write <= accept & reg_write;
         ex_halt      <= accept & halt;
         ex_illegal   <= accept & illegal;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ex_alu_op <= alu_op;
         ex_opnd_a <= opnd_a;
         ex_opnd_b <= use_imm ? imm_ext : rt_val;
         ex_dst    <= dst;
      end
   end

endmodule

//--- design/reg_file.sv
// eight general registers, two combinational read ports, one clocked write
// no internal bypass: a write is seen by readers after the edge
// every register clears on reset
`timescale 1ns/1ps
`include "wisc16_consts.svh"

module reg_file (
   input  logic                 clk,
   input  logic                 arst_n,
   input  wisc16_pkg::reg_sel_t rd_sel_a,
   input  wisc16_pkg::reg_sel_t rd_sel_b,
   input  wisc16_pkg::reg_sel_t wr_sel,
   input  logic                 wr_en,
   input  wisc16_pkg::word_t    wr_data,
   output wisc16_pkg::word_t    rd_data_a,
   output wisc16_pkg::word_t    rd_data_b
);
   import wisc16_pkg::*;

   localparam int NUM_REGS = 1 << `WISC_SEL_W;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   assign rd_data_a = regs[rd_sel_a];
   assign rd_data_b = regs[rd_sel_b];

endmodule

//--- design/decode_ctrl.sv
// control decoder, purely combinational
// opcodes outside the supported subset are flagged illegal and never write
// HALT and NOP write nothing either
`timescale 1ns/1ps
`include "wisc16_consts.svh"

module decode_ctrl (
   input  logic [`WISC_OPC_W-1:0] opcode,
   input  logic [`WISC_FN_W-1:0]  funct,
   output wisc16_pkg::alu_op_t    alu_op,
   output wisc16_pkg::dst_sel_t   dst_sel,
   output logic                   use_imm,
   output logic                   imm_long,
   output logic                   imm_signed,
   output logic                   reg_write,
   output logic                   halt,
   output logic                   illegal
);
   import wisc16_pkg::*;

   always_comb begin
      // defaults describe a NOP
      alu_op     = `WISC_ALU_ADD;
      dst_sel    = `WISC_DST_RD;
      use_imm    = 1'b0;
      imm_long   = 1'b0;
      imm_signed = 1'b0;
      reg_write  = 1'b0;
      halt       = 1'b0;
      illegal    = 1'b0;

      case (opcode)
         `WISC_OPC_HALT: halt = 1'b1;
         `WISC_OPC_NOP: ;
         `WISC_OPC_RTYPE: begin
            reg_write = 1'b1;
            case (funct)
               `WISC_FN_ADD: alu_op = `WISC_ALU_ADD;
               `WISC_FN_SUB: alu_op = `WISC_ALU_SUB;
               `WISC_FN_XOR: alu_op = `WISC_ALU_XOR;
               default:      alu_op = `WISC_ALU_AND;
            endcase
         end
         `WISC_OPC_ADDI: begin
            dst_sel    = `WISC_DST_RT;
            use_imm    = 1'b1;
            imm_signed = 1'b1;
            reg_write  = 1'b1;
         end
         `WISC_OPC_ANDNI: begin
            alu_op    = `WISC_ALU_ANDN;
            dst_sel   = `WISC_DST_RT;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         `WISC_OPC_LBI: begin
            alu_op     = `WISC_ALU_PASSB;
            dst_sel    = `WISC_DST_RS;
            use_imm    = 1'b1;
            imm_long   = 1'b1;
            imm_signed = 1'b1;
            reg_write  = 1'b1;
         end
         `WISC_OPC_SLBI: begin
            // rs shifted up, 8-bit immediate zero extended into the low byte
            alu_op    = `WISC_ALU_SLBI;
            dst_sel   = `WISC_DST_RS;
            use_imm   = 1'b1;
            imm_long  = 1'b1;
            reg_write = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

//--- design/wisc16_pkg.sv
// vector types shared by every block of the pipeline
// widths are taken from the constants header
`include "wisc16_consts.svh"

package wisc16_pkg;

   // one data word, also the register width
   typedef logic [`WISC_DATA_W-1:0] word_t;

   // register number, eight registers
   typedef logic [`WISC_SEL_W-1:0] reg_sel_t;

   // raw instruction word
   // opcode 15..11, rs 10..8, rt 7..5, rd 4..2, funct 1..0
   typedef logic [`WISC_DATA_W-1:0] inst_t;

   // operation code handed to the execute stage
   typedef logic [`WISC_ALU_W-1:0] alu_op_t;

   // which instruction field names the destination
   typedef logic [`WISC_DST_W-1:0] dst_sel_t;

endpackage

//--- include/wisc16_consts.svh
// widths, opcodes, function codes and ALU codes for the wisc16 pipeline
// opcode values follow the WISC encoding, only the supported subset is listed
// SUB computes operand A minus operand B (rs - rt)
`ifndef WISC16_CONSTS_SVH
`define WISC16_CONSTS_SVH

`define WISC_DATA_W 16
`define WISC_SEL_W  3
`define WISC_OPC_W  5
`define WISC_FN_W   2
`define WISC_ALU_W  3
`define WISC_DST_W  2

`define WISC_OPC_HALT  5'b00000
`define WISC_OPC_NOP   5'b00001
`define WISC_OPC_ADDI  5'b01000
`define WISC_OPC_ANDNI 5'b01011
`define WISC_OPC_SLBI  5'b10010
`define WISC_OPC_LBI   5'b11000
`define WISC_OPC_RTYPE 5'b11011

`define WISC_FN_ADD 2'b00
`define WISC_FN_SUB 2'b01
`define WISC_FN_XOR 2'b10
`define WISC_FN_AND 2'b11

`define WISC_ALU_ADD   3'd0
`define WISC_ALU_SUB   3'd1
`define WISC_ALU_AND   3'd2
`define WISC_ALU_XOR   3'd3
`define WISC_ALU_ANDN  3'd4
`define WISC_ALU_PASSB 3'd5
`define WISC_ALU_SLBI  3'd6

// destination field choice
`define WISC_DST_RD 2'd0
`define WISC_DST_RT 2'd1
`define WISC_DST_RS 2'd2

`endif
